// ==== Makefile ====
TOP := tb_dd_game

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== design/dd_char_ram.sv ====
// Character RAM, 16-bit words written a byte at a time by the CPU and read whole by video
`timescale 1ns/10ps

module dd_char_ram (
    input  logic               clk,
    input  dd_pkg::main_bus_t  main,
    input  logic               sel,
    output dd_pkg::byte_t      q,
    input  dd_pkg::char_addr_t char_addr,
    output dd_pkg::word_t      char_data
);
    import dd_pkg::*;

    word_t      mem [0:2047];
    char_addr_t cpu_word;
    logic       cpu_we;
    logic       cpu_rd;
    // Bit 1 is the high byte lane, bit 0 the low one
    logic [1:0] lane_we;

    assign cpu_word = main.addr[11:1];
    assign cpu_we   = main.cen && sel && !main.wrn;
    assign cpu_rd   = main.cen && sel && main.wrn;

    // Even byte address goes to the high lane
    assign lane_we = {2{cpu_we}} & {~main.addr[0], main.addr[0]};

    always_ff @(posedge clk) begin
        if (lane_we[1]) begin
            mem[cpu_word][15:8] <= main.dout;
        end
        if (lane_we[0]) begin
            mem[cpu_word][7:0] <= main.dout;
        end
    end

    // CPU byte, same lane rule as writes
    always_ff @(posedge clk) begin
        if (cpu_rd) begin
            if (main.addr[0]) begin
                q <= mem[cpu_word][7:0];
            end else begin
                q <= mem[cpu_word][15:8];
            end
        end
    end

    // Video port reads every cycle
    always_ff @(posedge clk) begin
        char_data <= mem[char_addr];
    end

endmodule

// ==== design/dd_game.sv ====
// Game top level, ties the main CPU bus to the char RAM, shared RAM and I/O registers
`timescale 1ns/10ps

module dd_game (
    input  logic                 clk,
    input  logic                 reset,
    // Main CPU bus
    input  dd_pkg::main_bus_t    main,
    output dd_pkg::byte_t        main_din,
    // MCU side
    input  dd_pkg::sub_bus_t     sub,
    output dd_pkg::byte_t        sub_din,
    output logic                 mcu_nmi,
    output logic                 mcu_irqmain,
    output logic                 mcu_rstb,
    // Sound CPU
    input  logic                 snd_rd,
    output dd_pkg::byte_t        snd_latch,
    output logic                 snd_irq,
    // Cabinet
    input  dd_pkg::byte_t        joystick1,
    input  dd_pkg::byte_t        dipsw_a,
    input  dd_pkg::byte_t        dipsw_b,
    // Video
    input  dd_pkg::char_addr_t   char_addr,
    output dd_pkg::word_t        char_data,
    output dd_pkg::video_ctrl_t  vctrl
);
    import dd_pkg::*;

    chip_sel_t sel;
    byte_t     cram_q;
    byte_t     shram_q;
    byte_t     io_q;

    dd_main_decode u_decode (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .main     ( main     ),
        .sel      ( sel      ),
        .cram_q   ( cram_q   ),
        .shram_q  ( shram_q  ),
        .io_q     ( io_q     ),
        .main_din ( main_din )
    );

    dd_char_ram u_char (
        .clk       ( clk       ),
        .main      ( main      ),
        .sel       ( sel.cram  ),
        .q         ( cram_q    ),
        .char_addr ( char_addr ),
        .char_data ( char_data )
    );

    dd_shared_ram u_shared (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .main        ( main        ),
        .sel         ( sel.shram   ),
        .q           ( shram_q     ),
        .sub         ( sub         ),
        .sub_din     ( sub_din     ),
        .mcu_nmi     ( mcu_nmi     ),
        .mcu_irqmain ( mcu_irqmain )
    );

    dd_io_regs u_io (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .main        ( main        ),
        .sel         ( sel.io      ),
        .q           ( io_q        ),
        .joystick1   ( joystick1   ),
        .dipsw_a     ( dipsw_a     ),
        .dipsw_b     ( dipsw_b     ),
        .mcu_irqmain ( mcu_irqmain ),
        .snd_rd      ( snd_rd      ),
        .snd_latch   ( snd_latch   ),
        .snd_irq     ( snd_irq     ),
        .vctrl       ( vctrl       ),
        .mcu_rstb    ( mcu_rstb    )
    );

endmodule

// ==== design/dd_io_regs.sv ====
// I/O registers: sound latch with IRQ, scroll and control writes, cabinet input reads
`timescale 1ns/10ps

module dd_io_regs (
    input  logic                clk,
    input  logic                reset,
    input  dd_pkg::main_bus_t   main,
    input  logic                sel,
    output dd_pkg::byte_t       q,
    input  dd_pkg::byte_t       joystick1,
    input  dd_pkg::byte_t       dipsw_a,
    input  dd_pkg::byte_t       dipsw_b,
    input  logic                mcu_irqmain,
    input  logic                snd_rd,
    output dd_pkg::byte_t       snd_latch,
    output logic                snd_irq,
    output dd_pkg::video_ctrl_t vctrl,
    output logic                mcu_rstb
);
    import dd_pkg::*;

    logic wr;
    logic rd;
    logic latch_wr;

    assign wr       = main.cen && sel && !main.wrn;
    assign rd       = main.cen && sel && main.wrn;
    assign latch_wr = wr && (main.addr == IO_LATCH);

    // Write-only registers
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_latch <= '0;
            vctrl     <= '0;
            mcu_rstb  <= 1'b0;
        end else if (wr) begin
            case (main.addr)
                IO_LATCH: snd_latch <= main.dout;
                IO_SCRH:  vctrl.scrhpos[7:0] <= main.dout;
                IO_SCRV:  vctrl.scrvpos[7:0] <= main.dout;
                IO_CTRL: begin
                    vctrl.scrhpos[8] <= main.dout[0];
                    vctrl.scrvpos[8] <= main.dout[1];
                    vctrl.flip       <= main.dout[2];
                    mcu_rstb         <= main.dout[3];
                end
                default: ;
            endcase
        end
    end

    // Sound IRQ, a new latch write outranks the acknowledge
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_irq <= 1'b0;
        end else if (latch_wr) begin
            snd_irq <= 1'b1;
        end else if (snd_rd) begin
            snd_irq <= 1'b0;
        end
    end

    // Read side, write-only addresses float
    always_ff @(posedge clk) begin
        if (rd) begin
            case (main.addr)
                IO_JOY:  q <= joystick1;
                IO_DIPA: q <= dipsw_a;
                IO_DIPB: q <= dipsw_b;
                IO_STAT: q <= {6'd0, snd_irq, mcu_irqmain};
                default: q <= OPEN_BUS;
            endcase
        end
    end

endmodule

// ==== design/dd_main_decode.sv ====
// Main CPU address decoder, produces chip selects and steers block read data to the CPU
`timescale 1ns/10ps

module dd_main_decode (
    input  logic              clk,
    input  logic              reset,
    input  dd_pkg::main_bus_t main,
    output dd_pkg::chip_sel_t sel,
    input  dd_pkg::byte_t     cram_q,
    input  dd_pkg::byte_t     shram_q,
    input  dd_pkg::byte_t     io_q,
    output dd_pkg::byte_t     main_din
);
    import dd_pkg::*;

    // Selection captured at the last read strobe
    chip_sel_t rd_sel;
    // Low until the first read strobe after reset
    logic      rd_vld;
    logic      rd_strobe;

    // Map ranges
    always_comb begin
        sel.cram  = main.addr <= CHAR_TOP;
        sel.shram = (main.addr >= SHRAM_BASE) && (main.addr < IO_BASE);
        sel.io    = (main.addr >= IO_BASE) && (main.addr <= IO_STAT);
    end

    assign rd_strobe = main.cen && main.wrn;

    // Blocks register their byte on the same strobe, so both sides line up
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_sel <= '0;
            rd_vld <= 1'b0;
        end else if (rd_strobe) begin
            rd_sel <= sel;
            rd_vld <= 1'b1;
        end
    end

    // Block q values only move on their own read strobe, so this holds too
    always_comb begin
        if (!rd_vld) begin
            main_din = '0;
        end else if (rd_sel.cram) begin
            main_din = cram_q;
        end else if (rd_sel.shram) begin
            main_din = shram_q;
        end else if (rd_sel.io) begin
            main_din = io_q;
        end else begin
            main_din = OPEN_BUS;
        end
    end

endmodule

// ==== design/dd_pkg.sv ====
// Bus widths, memory map and shared bus structs for the game glue RTL and its testbench
package dd_pkg;

    // Plain vector types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [12:0] cpu_addr_t;
    typedef logic [10:0] char_addr_t;
    typedef logic [8:0]  shram_addr_t;
    typedef logic [8:0]  scroll_t;

    // Main CPU memory map
    localparam cpu_addr_t CHAR_BASE  = 13'h0000;
    localparam cpu_addr_t CHAR_TOP   = 13'h0FFF;
    localparam cpu_addr_t SHRAM_BASE = 13'h1000;
    localparam cpu_addr_t IO_BASE    = 13'h1200;

    // I/O register addresses
    localparam cpu_addr_t IO_LATCH   = 13'h1200;
    localparam cpu_addr_t IO_SCRH    = 13'h1201;
    localparam cpu_addr_t IO_SCRV    = 13'h1202;
    localparam cpu_addr_t IO_CTRL    = 13'h1203;
    localparam cpu_addr_t IO_JOY     = 13'h1204;
    localparam cpu_addr_t IO_DIPA    = 13'h1205;
    localparam cpu_addr_t IO_DIPB    = 13'h1206;
    localparam cpu_addr_t IO_STAT    = 13'h1207;

    // Doorbell byte at the top of shared RAM
    localparam shram_addr_t MBOX_IDX = 9'h1FF;

    // Unmapped reads float high
    localparam byte_t OPEN_BUS = 8'hFF;

    typedef struct packed {
        logic      cen;
        cpu_addr_t addr;
        logic      wrn;
        byte_t     dout;
    } main_bus_t;

    typedef struct packed {
        logic cram;
        logic shram;
        logic io;
    } chip_sel_t;

    typedef struct packed {
        scroll_t scrhpos;
        scroll_t scrvpos;
        logic    flip;
    } video_ctrl_t;

    typedef struct packed {
        logic        cen;
        shram_addr_t addr;
        logic        wrn;
        byte_t       dout;
    } sub_bus_t;

endpackage

// ==== design/dd_shared_ram.sv ====
// RAM shared by the main CPU and the MCU, with a doorbell interrupt each way
`timescale 1ns/10ps

module dd_shared_ram (
    input  logic              clk,
    input  logic              reset,
    input  dd_pkg::main_bus_t main,
    input  logic              sel,
    output dd_pkg::byte_t     q,
    input  dd_pkg::sub_bus_t  sub,
    output dd_pkg::byte_t     sub_din,
    output logic              mcu_nmi,
    output logic              mcu_irqmain
);
    import dd_pkg::*;

    byte_t       mem [0:511];
    shram_addr_t main_a;
    logic        main_wr;
    logic        main_rd;
    logic        sub_wr;
    logic        sub_rd;

    // Doorbell events
    logic        main_ring;
    logic        main_ack;
    logic        sub_ring;
    logic        sub_ack;

    assign main_a  = main.addr[8:0];
    assign main_wr = main.cen && sel && !main.wrn;
    assign main_rd = main.cen && sel && main.wrn;

    // MCU bus covers only this RAM, no select needed
    assign sub_wr  = sub.cen && !sub.wrn;
    assign sub_rd  = sub.cen && sub.wrn;

    assign main_ring = main_wr && (main_a == MBOX_IDX);
    assign main_ack  = main_rd && (main_a == MBOX_IDX);
    assign sub_ring  = sub_wr && (sub.addr == MBOX_IDX);
    assign sub_ack   = sub_rd && (sub.addr == MBOX_IDX);

    // Main port written last so it wins a same-byte collision
    always_ff @(posedge clk) begin
        if (sub_wr) begin
            mem[sub.addr] <= sub.dout;
        end
        if (main_wr) begin
            mem[main_a] <= main.dout;
        end
    end

    always_ff @(posedge clk) begin
        if (main_rd) begin
            q <= mem[main_a];
        end
        if (sub_rd) begin
            sub_din <= mem[sub.addr];
        end
    end

    // Set beats clear when both land in one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mcu_nmi     <= 1'b0;
            mcu_irqmain <= 1'b0;
        end else begin
            if (main_ring) begin
                mcu_nmi <= 1'b1;
            end else if (sub_ack) begin
                mcu_nmi <= 1'b0;
            end
            if (sub_ring) begin
                mcu_irqmain <= 1'b1;
            end else if (main_ack) begin
                mcu_irqmain <= 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_dd_game.sv ====
// Random testbench for the game glue, plays main CPU, MCU and sound CPU against a memory map model
`timescale 1ns/10ps

module tb_dd_game;
    import dd_pkg::*;

    // Cycle budget, every bus cycle and video read takes two clocks
    localparam int RESET_CYC = 8;
    localparam int CRAM_CYC  = 2 * (300 + 200 + 100);
    localparam int SHRAM_CYC = 2 * 2 * 150;
    localparam int BELL_CYC  = 2 * 12;
    localparam int IO_CYC    = 2 * 9 * 50;
    localparam int OPEN_CYC  = 2 * 100;
    localparam int TOTAL_CYC = RESET_CYC + CRAM_CYC + SHRAM_CYC
                             + BELL_CYC + IO_CYC + OPEN_CYC;
    localparam int LIMIT_CYC = TOTAL_CYC + TOTAL_CYC / 10;

    logic        clk;
    logic        reset;
    main_bus_t   main;
    byte_t       main_din;
    sub_bus_t    sub;
    byte_t       sub_din;
    logic        mcu_nmi;
    logic        mcu_irqmain;
    logic        mcu_rstb;
    logic        snd_rd;
    byte_t       snd_latch;
    logic        snd_irq;
    byte_t       joystick1;
    byte_t       dipsw_a;
    byte_t       dipsw_b;
    char_addr_t  char_addr;
    word_t       char_data;
    video_ctrl_t vctrl;

    // Reference model of the memory map
    byte_t       cram_m [0:4095];
    logic        cram_ok [0:4095];
    byte_t       shram_m [0:511];
    logic        nmi_m;
    logic        irqmain_m;
    logic        sirq_m;
    logic        rstb_m;
    byte_t       latch_m;
    video_ctrl_t vctrl_m;
    byte_t       exp_main;
    byte_t       exp_sub;
    cpu_addr_t   cram_addr [0:299];
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    dd_game dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYC) begin
            $display("Timeout: the run went past %0d cycles", LIMIT_CYC);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %04h, actual %04h", name, exp, act);
        end
    endtask

    task automatic check_vctrl(input string name, input video_ctrl_t exp,
                               input video_ctrl_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %05h, actual %05h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic main_bus_t cpu_write(input cpu_addr_t a, input byte_t d);
        return '{cen: 1'b1, addr: a, wrn: 1'b0, dout: d};
    endfunction

    function automatic main_bus_t cpu_read(input cpu_addr_t a);
        return '{cen: 1'b1, addr: a, wrn: 1'b1, dout: 8'h00};
    endfunction

    function automatic sub_bus_t mcu_write(input shram_addr_t a, input byte_t d);
        return '{cen: 1'b1, addr: a, wrn: 1'b0, dout: d};
    endfunction

    function automatic sub_bus_t mcu_read(input shram_addr_t a);
        return '{cen: 1'b1, addr: a, wrn: 1'b1, dout: 8'h00};
    endfunction

    function automatic cpu_addr_t shared_addr(input shram_addr_t a);
        return SHRAM_BASE + cpu_addr_t'(a);
    endfunction

    // Byte the main CPU should see for a read of address a
    function automatic byte_t expect_read(input cpu_addr_t a);
        if (a <= CHAR_TOP) begin
            return cram_m[a[11:0]];
        end else if (a < IO_BASE) begin
            return shram_m[a[8:0]];
        end
        case (a)
            IO_JOY:  return joystick1;
            IO_DIPA: return dipsw_a;
            IO_DIPB: return dipsw_b;
            IO_STAT: return {6'd0, sirq_m, irqmain_m};
            default: return OPEN_BUS;
        endcase
    endfunction

    task automatic apply_write(input cpu_addr_t a, input byte_t d);
        if (a <= CHAR_TOP) begin
            cram_m[a[11:0]]  = d;
            cram_ok[a[11:0]] = 1'b1;
        end else if (a < IO_BASE) begin
            shram_m[a[8:0]] = d;
            if (a[8:0] == MBOX_IDX) begin
                nmi_m = 1'b1;
            end
        end else begin
            case (a)
                IO_LATCH: begin
                    latch_m = d;
                    sirq_m  = 1'b1;
                end
                IO_SCRH: vctrl_m.scrhpos[7:0] = d;
                IO_SCRV: vctrl_m.scrvpos[7:0] = d;
                IO_CTRL: begin
                    vctrl_m.scrhpos[8] = d[0];
                    vctrl_m.scrvpos[8] = d[1];
                    vctrl_m.flip       = d[2];
                    rstb_m             = d[3];
                end
                default: ;
            endcase
        end
    endtask

    // One strobe on both buses plus the sound ack, then an idle cycle
    task automatic bus_cycle(input main_bus_t m, input sub_bus_t s, input logic ack);
        @(negedge clk);
        main   = m;
        sub    = s;
        snd_rd = ack;
        // Reads return the contents from before this cycle's writes
        if (m.cen && m.wrn) begin
            exp_main = expect_read(m.addr);
        end
        if (s.cen && s.wrn) begin
            exp_sub = shram_m[s.addr];
        end
        // Clears go first so that a set in the same cycle wins
        if (ack) begin
            sirq_m = 1'b0;
        end
        if (s.cen && s.wrn && s.addr == MBOX_IDX) begin
            nmi_m = 1'b0;
        end
        if (m.cen && m.wrn && m.addr == shared_addr(MBOX_IDX)) begin
            irqmain_m = 1'b0;
        end
        if (s.cen && !s.wrn) begin
            shram_m[s.addr] = s.dout;
            if (s.addr == MBOX_IDX) begin
                irqmain_m = 1'b1;
            end
        end
        // Main port after the MCU, it wins a same-byte collision
        if (m.cen && !m.wrn) begin
            apply_write(m.addr, m.dout);
        end
        @(negedge clk);
        main.cen = 1'b0;
        sub.cen  = 1'b0;
        snd_rd   = 1'b0;
    endtask

    initial begin
        shram_addr_t sa;
        shram_addr_t sb;
        char_addr_t  w;
        word_t       mask;
        int          r;
        void'($urandom(97));
        reset     = 1'b1;
        main      = '0;
        sub       = '0;
        snd_rd    = 1'b0;
        joystick1 = '0;
        dipsw_a   = '0;
        dipsw_b   = '0;
        char_addr = '0;
        for (int i = 0; i < 4096; i++) begin
            cram_m[i]  = '0;
            cram_ok[i] = 1'b0;
        end
        for (int i = 0; i < 512; i++) begin
            shram_m[i] = '0;
        end
        nmi_m     = 1'b0;
        irqmain_m = 1'b0;
        sirq_m    = 1'b0;
        rstb_m    = 1'b0;
        latch_m   = '0;
        vctrl_m   = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Reset state
        check_bit("reset mcu_nmi", nmi_m, mcu_nmi);
        check_bit("reset mcu_irqmain", irqmain_m, mcu_irqmain);
        check_bit("reset snd_irq", sirq_m, snd_irq);
        check_bit("reset mcu_rstb", rstb_m, mcu_rstb);
        check_vctrl("reset vctrl", vctrl_m, vctrl);
        check_byte("reset main_din", 8'h00, main_din);
        check_byte("reset snd_latch", latch_m, snd_latch);

        // Character RAM, only written bytes are compared
        for (int k = 0; k < 300; k++) begin
            cram_addr[k] = cpu_addr_t'($urandom_range(32'h0FFF, 0));
            bus_cycle(cpu_write(cram_addr[k], byte_t'($urandom)), '0, 1'b0);
        end
        for (int k = 0; k < 200; k++) begin
            r = $urandom_range(299, 0);
            bus_cycle(cpu_read(cram_addr[r]), '0, 1'b0);
            check_byte("char ram cpu read", exp_main, main_din);
        end
        for (int k = 0; k < 100; k++) begin
            r = $urandom_range(299, 0);
            w = char_addr_t'(cram_addr[r] >> 1);
            @(negedge clk);
            char_addr = w;
            @(negedge clk);
            mask = {cram_ok[{w, 1'b0}] ? 8'hFF : 8'h00, cram_ok[{w, 1'b1}] ? 8'hFF : 8'h00};
            check_word("char ram video read",
                       {cram_m[{w, 1'b0}], cram_m[{w, 1'b1}]} & mask, char_data & mask);
        end

        // Shared RAM, one round in four collides on the same byte
        for (int k = 0; k < 150; k++) begin
            sa = shram_addr_t'($urandom_range(510, 0));
            sb = ($urandom_range(3, 0) == 0) ? sa : shram_addr_t'($urandom_range(510, 0));
            bus_cycle(cpu_write(shared_addr(sa), byte_t'($urandom)),
                      mcu_write(sb, byte_t'($urandom)), 1'b0);
            bus_cycle(cpu_read(shared_addr(sb)), mcu_read(sa), 1'b0);
            check_byte("shared ram main reads mcu byte", exp_main, main_din);
            check_byte("shared ram mcu reads main byte", exp_sub, sub_din);
        end

        // Doorbells both ways, then set and clear in one cycle
        bus_cycle(cpu_write(shared_addr(MBOX_IDX), byte_t'($urandom)), '0, 1'b0);
        check_bit("main rings mcu", nmi_m, mcu_nmi);
        bus_cycle('0, mcu_read(MBOX_IDX), 1'b0);
        check_byte("mcu reads doorbell byte", exp_sub, sub_din);
        check_bit("mcu read clears nmi", nmi_m, mcu_nmi);
        bus_cycle('0, mcu_write(MBOX_IDX, byte_t'($urandom)), 1'b0);
        check_bit("mcu rings main", irqmain_m, mcu_irqmain);
        bus_cycle(cpu_read(IO_STAT), '0, 1'b0);
        check_byte("status shows mcu doorbell", exp_main, main_din);
        bus_cycle(cpu_read(shared_addr(MBOX_IDX)), '0, 1'b0);
        check_byte("main reads doorbell byte", exp_main, main_din);
        check_bit("main read clears irqmain", irqmain_m, mcu_irqmain);
        bus_cycle(cpu_read(IO_STAT), '0, 1'b0);
        check_byte("status after doorbell clear", exp_main, main_din);
        bus_cycle(cpu_write(shared_addr(MBOX_IDX), byte_t'($urandom)), '0, 1'b0);
        bus_cycle(cpu_write(shared_addr(MBOX_IDX), byte_t'($urandom)),
                  mcu_read(MBOX_IDX), 1'b0);
        check_bit("nmi set and clear together", nmi_m, mcu_nmi);
        check_byte("mcu read during main write", exp_sub, sub_din);
        bus_cycle('0, mcu_read(MBOX_IDX), 1'b0);
        check_bit("nmi cleared afterwards", nmi_m, mcu_nmi);
        check_byte("mcu reads newest doorbell byte", exp_sub, sub_din);
        bus_cycle('0, mcu_write(MBOX_IDX, byte_t'($urandom)), 1'b0);
        bus_cycle(cpu_read(shared_addr(MBOX_IDX)),
                  mcu_write(MBOX_IDX, byte_t'($urandom)), 1'b0);
        check_bit("irqmain set and clear together", irqmain_m, mcu_irqmain);
        check_byte("main read during mcu write", exp_main, main_din);
        bus_cycle(cpu_read(shared_addr(MBOX_IDX)), '0, 1'b0);
        check_bit("irqmain cleared afterwards", irqmain_m, mcu_irqmain);
        check_byte("main reads newest doorbell byte", exp_main, main_din);

        // I/O registers and cabinet inputs
        for (int k = 0; k < 50; k++) begin
            bus_cycle(cpu_write(IO_LATCH, byte_t'($urandom)), '0, $urandom_range(3, 0) == 0);
            check_byte("sound latch", latch_m, snd_latch);
            check_bit("sound irq after latch write", sirq_m, snd_irq);
            bus_cycle(cpu_read(IO_STAT), '0, 1'b0);
            check_byte("status shows sound irq", exp_main, main_din);
            bus_cycle('0, '0, 1'b1);
            check_bit("sound irq after ack", sirq_m, snd_irq);
            bus_cycle(cpu_write(IO_SCRH, byte_t'($urandom)), '0, 1'b0);
            bus_cycle(cpu_write(IO_SCRV, byte_t'($urandom)), '0, 1'b0);
            bus_cycle(cpu_write(IO_CTRL, byte_t'($urandom)), '0, 1'b0);
            check_vctrl("scroll and flip", vctrl_m, vctrl);
            check_bit("mcu reset release", rstb_m, mcu_rstb);
            joystick1 = byte_t'($urandom);
            dipsw_a   = byte_t'($urandom);
            dipsw_b   = byte_t'($urandom);
            bus_cycle(cpu_read(IO_JOY), '0, 1'b0);
            check_byte("joystick read", exp_main, main_din);
            bus_cycle(cpu_read(IO_DIPA), '0, 1'b0);
            check_byte("dip a read", exp_main, main_din);
            bus_cycle(cpu_read(IO_DIPB), '0, 1'b0);
            check_byte("dip b read", exp_main, main_din);
        end

        // Unmapped space
        for (int k = 0; k < 100; k++) begin
            bus_cycle(cpu_read(cpu_addr_t'($urandom_range(32'h1FFF, 32'h1208))), '0, 1'b0);
            check_byte("open bus read", OPEN_BUS, main_din);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/dd_pkg.sv
design/dd_main_decode.sv
design/dd_char_ram.sv
design/dd_shared_ram.sv
design/dd_io_regs.sv
design/dd_game.sv
sim/tb_dd_game.sv
